// ==== verilog.f ====
logic/socPkg.sv
logic/serialPkg.sv
logic/uartReceiver.sv
logic/commandRegisters.sv
logic/pwmGenerator.sv
logic/dacSpiMaster.sv
logic/beMicroTop.sv
verification/beMicroTopTb.sv

// ==== Makefile ====
# Verilator build and run of the BeMicro MAX 10 peripheral testbench.
# Exit status of "make run" is the simulator's, non-zero on failure.

VERILATOR ?= verilator
TOP       ?= beMicroTopTb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

// ==== verification/beMicroTopTb.sv ====
/*
 * Testbench for the BeMicro MAX 10 peripheral wrapper. Sends UART
 * commands on PMOD_D[2], watches the LED, PWM and DAC SPI pins and
 * checks them with assertions against a small register model.
 */
`timescale 1ns/1ps
`default_nettype none

module beMicroTopTb;

    localparam int clkPeriod = 20;
    localparam int bitCycles = 16;
    localparam int halfSclk = 2;
    // 8N1 frame plus one idle bit between bytes
    localparam int byteCycles = 11 * bitCycles;
    localparam int frameTimeout = 24 * 4 * halfSclk;
    // settle past one period, then one counted period
    localparam int pwmWindow = 260 + 256;
    localparam int sentBytes = 32;
    localparam int frameWindows = 3;
    localparam int pwmWindows = 4;
    localparam int watchdogCycles =
        2 * (sentBytes * byteCycles + frameWindows * frameTimeout + pwmWindows * pwmWindow);
    localparam logic [7:0] unknownAddr = 8'h5A;

    logic       clk;
    logic [4:1] pb;
    logic       rxLine;
    logic [8:1] userLed;
    logic       ldacN;
    logic       dacRstN;
    logic       scl;
    logic       sda;
    logic       syncN;
    wire  [3:0] pmodA;
    wire  [3:0] pmodD;

    // expected register contents
    socPkg::ctrlRegs_t model;
    logic [8:1]        expLedPins;
    // LED may move while a ledAddr data byte is received
    logic              ledSettling;
    // SPI frame expected after a dacHighAddr write
    logic              frameAllowed;
    integer            seed;

    // SPI monitor state
    logic [23:0] frameBits;
    int          bitCount;
    int          frameCount;
    logic        prevScl;
    logic        prevSync;

    assign pmodD[2]   = rxLine;

    beMicroTop #(
        .clksPerBit     (bitCycles),
        .sclkHalfPeriod (halfSclk)
    ) dut0 (
        .SYS_CLK        (clk),
        .PB             (pb),
        .USER_LED       (userLed),
        .AD5681R_LDACn  (ldacN),
        .AD5681R_RSTn   (dacRstN),
        .AD5681R_SCL    (scl),
        .AD5681R_SDA    (sda),
        .AD5681R_SYNCn  (syncN),
        .PMOD_A         (pmodA),
        .PMOD_D         (pmodD)
    );

    task automatic abortRun();
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    task automatic valueMismatch(input string name, input int expected, input int actual);
        $display("** Error at %0d ns: %s expected 0x%0h, got 0x%0h",
            $time, name, expected, actual);
        abortRun();
    endtask

    task automatic plainFailure(input string what);
        $display("** Error at %0d ns: %s", $time, what);
        abortRun();
    endtask

    // one 8N1 character, LSB first, then an idle bit
    task automatic sendByte(input logic [7:0] data, input logic badStop);
        @(negedge clk);
        rxLine = 1'b0;
        repeat (bitCycles) @(negedge clk);
        for (int i = 0; i < 8; i++) begin
            rxLine = data[i];
            repeat (bitCycles) @(negedge clk);
        end
        rxLine = !badStop;
        repeat (bitCycles) @(negedge clk);
        rxLine = 1'b1;
        repeat (bitCycles) @(negedge clk);
    endtask

    // register rule of the command map
    task automatic applyToModel(input logic [7:0] addr, input logic [7:0] data);
        case (addr)
            socPkg::ledAddr: begin
                model.ledLevel = data;
                // LEDs are active low on the board
                expLedPins     = ~data;
            end
            socPkg::pwmAddr: begin
                model.pwmDuty = data;
            end
            socPkg::dacLowAddr: begin
                model.dacCode[7:0] = data;
            end
            socPkg::dacHighAddr: begin
                // only the low nibble counts
                model.dacCode[11:8] = data[3:0];
            end
            default: begin
                // unknown address, nothing held
            end
        endcase
    endtask

    task automatic writeRegister(input logic [7:0] addr, input logic [7:0] data);
        sendByte(addr, 1'b0);
        ledSettling = (addr == socPkg::ledAddr);
        sendByte(data, 1'b0);
        applyToModel(addr, data);
        ledSettling = 1'b0;
    endtask

    task automatic awaitDacFrame(input int target);
        int waited;
        waited = 0;
        while (frameCount < target && waited < frameTimeout) begin
            @(negedge clk);
            waited++;
        end
        assert (frameCount == target)
            else plainFailure($sformatf("expected %0d SPI frames, saw %0d", target, frameCount));
        assert (syncN == 1'b1)
            else valueMismatch("AD5681R_SYNCn", 1, int'(syncN));
        frameAllowed = 1'b0;
    endtask

    // command 0011, then the 12-bit code, then eight zero pad bits
    task automatic checkDacFrame();
        logic [23:0] expected;
        expected = {4'b0011, model.dacCode, 8'h00};
        assert (bitCount == 24)
            else plainFailure($sformatf("SPI frame had %0d bits", bitCount));
        assert (frameBits == expected)
            else valueMismatch("AD5681R_SDA frame", int'(expected), int'(frameBits));
        frameCount++;
    endtask

    task automatic checkPwmDuty();
        int highCount;
        highCount = 0;
        repeat (260) @(negedge clk);
        repeat (256) begin
            @(negedge clk);
            if (pmodA[0] === 1'b1) begin
                highCount++;
            end
        end
        assert (highCount == int'(model.pwmDuty))
            else valueMismatch("PMOD_A[0] high cycles", int'(model.pwmDuty), highCount);
    endtask

    // SPI monitor, SDA taken after each SCL fall inside SYNCn
    always @(negedge clk) begin
        if (!pb[1]) begin
            bitCount = 0;
        end else begin
            if (prevSync && !syncN) begin
                bitCount  = 0;
                frameBits = '0;
            end
            if (!syncN && prevScl && !scl) begin
                frameBits = {frameBits[22:0], sda};
                bitCount  = bitCount + 1;
            end
            if (!prevSync && syncN) begin
                checkDacFrame();
            end
        end
        prevScl  = scl;
        prevSync = syncN;
    end

    ldacTiedLow: assert property (@(posedge clk) ldacN == 1'b0)
        else valueMismatch("AD5681R_LDACn", 0, int'(ldacN));
    dacResetTiedHigh: assert property (@(posedge clk) dacRstN == 1'b1)
        else valueMismatch("AD5681R_RSTn", 1, int'(dacRstN));
    sclHighOutsideFrame: assert property (@(posedge clk) disable iff (!pb[1]) syncN |-> scl)
        else plainFailure("AD5681R_SCL went low while SYNCn was high");
    sdaLowOutsideFrame: assert property (@(posedge clk) disable iff (!pb[1]) syncN |-> !sda)
        else valueMismatch("AD5681R_SDA", 0, int'(sda));
    noUnexpectedFrame: assert property (@(posedge clk) disable iff (!pb[1])
        !frameAllowed |-> syncN)
        else plainFailure("SPI frame started without a DAC high write");
    ledFollowsModel: assert property (@(posedge clk) disable iff (!pb[1])
        !ledSettling |-> userLed == expLedPins)
        else valueMismatch("USER_LED", int'(expLedPins), int'(userLed));

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    initial begin
        repeat (watchdogCycles) @(posedge clk);
        plainFailure($sformatf("watchdog expired after %0d cycles", watchdogCycles));
    end

    initial begin : mainSequence
        logic [7:0] data;
        seed         = 69;
        pb           = 4'b1110;
        rxLine       = 1'b1;
        model        = '0;
        // all LEDs dark
        expLedPins   = 8'hFF;
        ledSettling  = 1'b0;
        frameAllowed = 1'b0;
        frameCount   = 0;
        frameBits    = '0;
        prevScl      = 1'b1;
        prevSync     = 1'b1;
        repeat (2) @(negedge clk);
        pb[1] = 1'b1;
        @(negedge clk);

        // idle levels out of reset
        assert (userLed == 8'hFF) else valueMismatch("USER_LED", 'hFF, int'(userLed));
        assert (syncN == 1'b1) else valueMismatch("AD5681R_SYNCn", 1, int'(syncN));
        assert (scl == 1'b1) else valueMismatch("AD5681R_SCL", 1, int'(scl));
        assert (pmodA[0] == 1'b0) else valueMismatch("PMOD_A[0]", 0, int'(pmodA[0]));

        repeat (4) begin
            data = 8'($random(seed));
            writeRegister(socPkg::ledAddr, data);
            assert (userLed == expLedPins)
                else valueMismatch("USER_LED", int'(expLedPins), int'(userLed));
        end

        // low byte alone holds the code, no frame
        writeRegister(socPkg::dacLowAddr, 8'($random(seed)));
        repeat (frameTimeout) @(negedge clk);
        assert (frameCount == 0) else plainFailure("SPI frame after a DAC low write alone");
        for (int n = 1; n <= 2; n++) begin
            writeRegister(socPkg::dacLowAddr, 8'($random(seed)));
            frameAllowed = 1'b1;
            writeRegister(socPkg::dacHighAddr, 8'($random(seed)));
            awaitDacFrame(n);
        end

        writeRegister(socPkg::pwmAddr, 8'h00);
        checkPwmDuty();
        writeRegister(socPkg::pwmAddr, 8'hFF);
        checkPwmDuty();
        writeRegister(socPkg::pwmAddr, 8'($random(seed)));
        checkPwmDuty();

        // bad stop bit drops the data byte and restarts the pairing
        writeRegister(socPkg::ledAddr, 8'hA5);
        sendByte(socPkg::ledAddr, 1'b0);
        sendByte(8'h3C, 1'b1);
        data = 8'($random(seed));
        writeRegister(socPkg::ledAddr, data);
        assert (userLed == expLedPins)
            else valueMismatch("USER_LED", int'(expLedPins), int'(userLed));

        // unknown address touches nothing
        writeRegister(unknownAddr, 8'($random(seed)));
        checkPwmDuty();

        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== logic/beMicroTop.sv ====
/*
 * BeMicro MAX 10 board wrapper. Maps kit pins onto the UART command
 * decoder, the PWM output and the AD5681R DAC. PB[1] is the reset,
 * UART input on PMOD_D[2], PWM out on PMOD_A[0].
 */
`timescale 1ns/1ps
`default_nettype none

module beMicroTop #(
    parameter int clksPerBit     = 434,
    parameter int sclkHalfPeriod = 4
) (
    // 50 MHz board clock
    input  logic       SYS_CLK,
    input  logic [4:1] PB,
    output logic [8:1] USER_LED,
    output logic       AD5681R_LDACn,
    output logic       AD5681R_RSTn,
    output logic       AD5681R_SCL,
    output logic       AD5681R_SDA,
    output logic       AD5681R_SYNCn,
    inout  wire  [3:0] PMOD_A,
    inout  wire  [3:0] PMOD_D
);

    logic                 clk;
    logic                 rstN;
    serialPkg::uartByte_t rxByte;
    logic                 rxValid;
    socPkg::ctrlRegs_t    ctrl;
    logic                 dacStart;
    logic                 pwm;

    assign clk  = SYS_CLK;
    // button reads low when pressed
    assign rstN = PB[1];

    uartReceiver #(
        .clksPerBit (clksPerBit)
    ) uartReceiver0 (
        .clk,
        .rstN,
        .rx         (PMOD_D[2]),
        .rxByte,
        .rxValid
    );

    commandRegisters commandRegisters0 (
        .clk,
        .rstN,
        .rxByte,
        .rxValid,
        .ctrl,
        .dacStart
    );

    pwmGenerator pwmGenerator0 (
        .clk,
        .rstN,
        .duty       (ctrl.pwmDuty),
        .pwm
    );

    dacSpiMaster #(
        .sclkHalfPeriod (sclkHalfPeriod)
    ) dacSpiMaster0 (
        .clk,
        .rstN,
        .dacStart,
        .code           (ctrl.dacCode),
        .syncN          (AD5681R_SYNCn),
        .sclk           (AD5681R_SCL),
        .sdo            (AD5681R_SDA)
    );

    assign PMOD_A[0]   = pwm;
    // rest of PMOD_A unused, PMOD_D left to the UART host
    assign PMOD_A[3:1] = 3'bzzz;

    // LEDs light on a low pin
    assign USER_LED = ~ctrl.ledLevel;

    // input register updates straight through, DAC reset held off
    assign AD5681R_LDACn = 1'b0;
    assign AD5681R_RSTn  = 1'b1;

endmodule

`default_nettype wire

// ==== logic/dacSpiMaster.sv ====
/*
 * SPI master for the AD5681R. On dacStart, shifts one 24-bit
 * write-and-update frame out MSB first under SYNCn. SCL idles high,
 * SDA changes while SCL is high, the device samples on SCL falling.
 */
`timescale 1ns/1ps
`default_nettype none

module dacSpiMaster #(
    parameter int sclkHalfPeriod = 4
) (
    input  logic        clk,
    input  logic        rstN,
    input  logic        dacStart,
    input  logic [11:0] code,
    output logic        syncN,
    output logic        sclk,
    output logic        sdo
);

    localparam int divWidth = $clog2(sclkHalfPeriod + 1);
    localparam logic [divWidth-1:0] halfLast = divWidth'(sclkHalfPeriod - 1);

    serialPkg::dacFrame_t frame;
    logic [23:0]          shiftReg;
    logic                 busy;
    logic [divWidth-1:0]  divCnt;
    logic [4:0]           bitCnt;
    logic                 halfTick;

    always_comb begin
        frame.command = serialPkg::dacWriteUpdate;
        frame.code    = code;
        frame.pad     = 8'h00;
    end

    // end of one SCL half period
    assign halfTick = (divCnt == halfLast);
    assign syncN    = !busy;
    // SDA low whenever no frame is running
    assign sdo      = busy && shiftReg[23];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            busy   <= 1'b0;
            sclk   <= 1'b1;
            divCnt <= '0;
            bitCnt <= '0;
        end else if (!busy) begin
            divCnt <= '0;
            bitCnt <= '0;
            sclk   <= 1'b1;
            // starts are ignored while a frame runs
            if (dacStart) begin
                busy <= 1'b1;
            end
        end else begin
            divCnt <= halfTick ? '0 : divCnt + 1'b1;
            if (halfTick) begin
                if (sclk) begin
                    // device samples here
                    sclk <= 1'b0;
                end else begin
                    sclk <= 1'b1;
                    // one half period after the 24th falling edge
                    if (bitCnt == 5'd23) begin
                        busy <= 1'b0;
                    end else begin
                        bitCnt <= bitCnt + 1'b1;
                    end
                end
            end
        end
    end

    // frame shift register, next bit appears as SCL rises
    always_ff @(posedge clk) begin
        if (!rstN) begin
            shiftReg <= '0;
        end else if (!busy && dacStart) begin
            shiftReg <= frame;
        end else if (busy && halfTick && !sclk) begin
            shiftReg <= {shiftReg[22:0], 1'b0};
        end
    end

    // no stray SCL edge outside a SYNCn frame
    sclkIdleHigh: assert property (@(posedge clk) disable iff (!rstN)
        syncN |-> sclk);

endmodule

`default_nettype wire

// ==== logic/pwmGenerator.sv ====
/*
 * Free-running 8-bit PWM. The duty input is latched at period wrap,
 * so a period never mixes two duties. Output high while count < duty.
 */
`timescale 1ns/1ps
`default_nettype none

module pwmGenerator (
    input  logic       clk,
    input  logic       rstN,
    input  logic [7:0] duty,
    output logic       pwm
);

    logic [7:0] count;
    // duty in force for the current period
    logic [7:0] dutyLatched;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            count       <= 8'h00;
            dutyLatched <= 8'h00;
        end else begin
            // wraps 255 -> 0 on its own
            count <= count + 8'h01;
            // new duty lands exactly as count returns to 0
            if (count == 8'hFF) begin
                dutyLatched <= duty;
            end
        end
    end

    // duty 0 gives constant low, 255 one low cycle per period
    assign pwm = (count < dutyLatched);

endmodule

`default_nettype wire

// ==== logic/commandRegisters.sv ====
/*
 * Command decoder. Pairs received bytes into address/data commands and
 * holds the LED, PWM and DAC control registers. A write to the DAC
 * high byte pulses dacStart together with the updated code.
 */
`timescale 1ns/1ps
`default_nettype none

module commandRegisters (
    input  logic                 clk,
    input  logic                 rstN,
    input  serialPkg::uartByte_t rxByte,
    input  logic                 rxValid,
    output socPkg::ctrlRegs_t    ctrl,
    output logic                 dacStart
);

    // high while an address byte waits for its data byte
    logic             phase;
    socPkg::regAddr_t addrReg;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            phase    <= 1'b0;
            addrReg  <= socPkg::ledAddr;
            ctrl     <= socPkg::ctrlResetValue;
            dacStart <= 1'b0;
        end else begin
            dacStart <= 1'b0;
            if (rxValid) begin
                if (rxByte.frameError) begin
                    // bad byte, next good byte is an address again
                    phase <= 1'b0;
                end else if (!phase) begin
                    addrReg <= socPkg::regAddr_t'(rxByte.data);
                    phase   <= 1'b1;
                end else begin
                    phase <= 1'b0;
                    case (addrReg)
                        socPkg::ledAddr: begin
                            ctrl.ledLevel <= rxByte.data;
                        end
                        socPkg::pwmAddr: begin
                            ctrl.pwmDuty <= rxByte.data;
                        end
                        socPkg::dacLowAddr: begin
                            ctrl.dacCode[7:0] <= rxByte.data;
                        end
                        socPkg::dacHighAddr: begin
                            // upper nibble of the data byte is ignored
                            ctrl.dacCode[11:8] <= rxByte.data[3:0];
                            dacStart           <= 1'b1;
                        end
                        default: begin
                            // unknown address, command consumed
                        end
                    endcase
                end
            end
        end
    end

    // frame launch only ever follows a received data byte
    dacStartFollowsByte: assert property (@(posedge clk) disable iff (!rstN)
        dacStart |-> $past(rxValid));

endmodule

`default_nettype wire

// ==== logic/uartReceiver.sv ====
/*
 * 8N1 UART receiver with a two-flop input synchronizer.
 * Samples every bit at mid-bit; clksPerBit is clk frequency over baud.
 * rxValid pulses for one cycle at the middle of the stop bit.
 */
`timescale 1ns/1ps
`default_nettype none

module uartReceiver #(
    parameter int clksPerBit = 434
) (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 rx,
    output serialPkg::uartByte_t rxByte,
    output logic                 rxValid
);

    localparam int cntWidth = $clog2(clksPerBit + 1);
    localparam logic [cntWidth-1:0] halfBit = cntWidth'(clksPerBit / 2 - 1);
    localparam logic [cntWidth-1:0] fullBit = cntWidth'(clksPerBit - 1);

    typedef enum logic [1:0] {idleSt, startSt, dataSt, stopSt} rxState_t;

    rxState_t            state;
    logic [1:0]          rxSync;
    logic                rxLast;
    logic [cntWidth-1:0] bitTimer;
    logic [2:0]          bitIdx;
    logic [7:0]          dataShift;
    logic                sampleTick;

    // one full bit time since the last sample point
    assign sampleTick = (bitTimer == fullBit);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            // line idles high
            rxSync   <= 2'b11;
            rxLast   <= 1'b1;
            state    <= idleSt;
            bitTimer <= '0;
            bitIdx   <= '0;
            rxValid  <= 1'b0;
        end else begin
            rxSync  <= {rxSync[0], rx};
            rxLast  <= rxSync[1];
            rxValid <= 1'b0;
            case (state)
                idleSt: begin
                    bitTimer <= '0;
                    // falling edge opens a start bit
                    if (rxLast && !rxSync[1]) begin
                        state <= startSt;
                    end
                end
                startSt: begin
                    if (bitTimer == halfBit) begin
                        bitTimer <= '0;
                        bitIdx   <= '0;
                        // glitch, start bit gone high again by mid-bit
                        state    <= rxSync[1] ? idleSt : dataSt;
                    end else begin
                        bitTimer <= bitTimer + 1'b1;
                    end
                end
                dataSt: begin
                    if (sampleTick) begin
                        bitTimer <= '0;
                        bitIdx   <= bitIdx + 1'b1;
                        if (bitIdx == 3'd7) begin
                            state <= stopSt;
                        end
                    end else begin
                        bitTimer <= bitTimer + 1'b1;
                    end
                end
                default: begin
                    if (sampleTick) begin
                        rxValid <= 1'b1;
                        state   <= idleSt;
                    end else begin
                        bitTimer <= bitTimer + 1'b1;
                    end
                end
            endcase
        end
    end

    // data path, LSB arrives first
    always_ff @(posedge clk) begin
        if (!rstN) begin
            dataShift <= '0;
            rxByte    <= '0;
        end else begin
            if (state == dataSt && sampleTick) begin
                dataShift <= {rxSync[1], dataShift[7:1]};
            end
            if (state == stopSt && sampleTick) begin
                rxByte.data       <= dataShift;
                rxByte.frameError <= !rxSync[1];
            end
        end
    end

    // decoder counts on single strobes per byte
    rxValidSinglePulse: assert property (@(posedge clk) disable iff (!rstN)
        rxValid |=> !rxValid);

endmodule

`default_nettype wire

// ==== logic/serialPkg.sv ====
/*
 * Frame types of the serial links: the received UART byte and the
 * 24-bit AD5681R SPI word, plus the DAC command code.
 */
`default_nettype none

package serialPkg;

    // one received 8N1 character
    typedef struct packed {
        logic [7:0] data;
        // stop bit sampled low
        logic       frameError;
    } uartByte_t;

    // AD5681R input shift register, sent MSB first
    typedef struct packed {
        logic [3:0]  command;
        logic [11:0] code;
        // don't care bits, sent as zero
        logic [7:0]  pad;
    } dacFrame_t;

    // write and update DAC register
    parameter logic [3:0] dacWriteUpdate = 4'b0011;

endpackage

`default_nettype wire

// ==== logic/socPkg.sv ====
/*
 * Register map and control-side types of the command decoder.
 * Shared by the decoder and the board wrapper, referenced by scoped name.
 */
`default_nettype none

package socPkg;

    // address byte of a two-byte command, anything else is dropped
    typedef enum logic [7:0] {
        ledAddr     = 8'h00,
        pwmAddr     = 8'h01,
        // low code bits, held until the high byte arrives
        dacLowAddr  = 8'h02,
        // top nibble of the code, launches the frame
        dacHighAddr = 8'h03
    } regAddr_t;

    // control levels leaving the decoder
    typedef struct packed {
        logic [7:0]  ledLevel;
        logic [7:0]  pwmDuty;
        logic [11:0] dacCode;
    } ctrlRegs_t;

    parameter ctrlRegs_t ctrlResetValue = '{ledLevel: 8'h00, pwmDuty: 8'h00, dacCode: 12'h000};

endpackage

`default_nettype wire
